/* filelist.f */
source/vsaIsaPkg.sv
source/vsaCorePkg.sv
source/vsaRegFile.sv
source/vsaSequencer.sv
source/vsaAlu.sv
source/vsaBranchUnit.sv
source/vsaCommit.sv
source/vsaCore.sv
bench/vsaCore_sva.sv
bench/vsaCoreTb.sv

/* bench/vsaCoreTb.sv */
// ~~~~~~~~~~~~~~~~~~~~
// testbench for the vsa core
// memory models, directed and random programs,
// reference step function, compare process
// ~~~~~~~~~~~~~~~~~~~~
module vsaCoreTb;
    timeunit 1ns;
    timeprecision 1ps;
    import vsaIsaPkg::*;
    import vsaCorePkg::*;

    localparam pcAddr bootPc = 5'd0;

    // architectural state after one instruction
    typedef struct packed {
        dataWord [3:0] regs;    // regs[0] kept at zero
        pcAddr         pc;
        dataWord       addr;    // data address of LW/SW
        dataWord       stData;
        logic          store;
    } archState;

    logic     clock = 1'b0;
    logic     rst = 1'b1;
    instrWord instr = '0;
    dataWord  dataIn = '0;
    pcAddr    pc;
    dataWord  dataAddr;
    dataWord  dataOut;
    logic     write;

    instrWord imem [32];    // indexed by pc with odd slots unused
    dataWord  memArr [32];  // written by core stores
    dataWord  refMem [32];  // reference copy
    archState refS;
    int       slot;         // next free program slot

    vsaCore #(.resetPc(bootPc)) u_dut (
        .clock    (clock),
        .rst      (rst),
        .pc       (pc),
        .instr    (instr),
        .dataAddr (dataAddr),
        .dataIn   (dataIn),
        .dataOut  (dataOut),
        .write    (write)
    );

    always #2 clock = ~clock;  // 4 ns period

    // zero-wait instruction memory plus store side of data memory
    always @(posedge clock) begin
        instr <= imem[pc];
        if (write)
            memArr[dataAddr] <= dataOut;
    end

    function automatic instrWord encodeR(funcE f, regIndex s1, regIndex s2, regIndex d);
        return {ALUOP, s1, s2, d, f};
    endfunction

    function automatic instrWord encodeI(opcodeE op, regIndex s1, regIndex s2, immField imm);
        return {op, s1, s2, imm};
    endfunction

    // one ISA instruction with arithmetic mod 32
    function automatic archState step(archState s, dataWord mem [32], instrWord iw);
        archState n;
        opcodeE   op;
        dataWord  a;
        dataWord  b;
        dataWord  res;
        pcAddr    npc;
        op       = opcodeE'(iw[11:9]);
        a        = s.regs[iw[8:7]];
        b        = s.regs[iw[6:5]];
        npc      = s.pc + 5'd2;
        n        = s;
        n.pc     = npc;
        n.addr   = a + iw[4:0];  // used by LW/SW only
        n.stData = b;
        n.store  = (op == SW);
        case (op)
            LW:   n.regs[iw[6:5]] = mem[n.addr];
            ADDI: n.regs[iw[6:5]] = a + iw[4:0];
            SUBI: n.regs[iw[6:5]] = a - iw[4:0];
            BEQZ: begin
                if (a == '0)
                    n.pc = npc + 5'(iw[3:0] * 2);  // imm[4] has no effect
            end
            ALUOP: begin
                case (funcE'(iw[2:0]))
                    ADD:     res = a + b;
                    SUB:     res = a - b;
                    AND:     res = a & b;
                    OR:      res = a | b;
                    XOR:     res = a ^ b;
                    NOT:     res = ~a;
                    SRL:     res = a >> 1;
                    default: res = dataWord'($signed(a) >>> 1);
                endcase
                n.regs[iw[4:3]] = res;
            end
            default: ;
        endcase
        n.regs[0] = '0;
        return n;
    endfunction

    task automatic abortRun();
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic checkPc(pcAddr expected);
        if (pc !== expected) begin
            $display("ERROR: time %0d ns: pc expected %0d, actual %0d", $time, expected, pc);
            abortRun();
        end
    endtask

    task automatic checkData(string name, dataWord actual, dataWord expected);
        if (actual !== expected) begin
            $display("ERROR: time %0d ns: %s expected %0d, actual %0d",
                     $time, name, expected, actual);
            abortRun();
        end
    endtask

    task automatic checkStrobe(logic expected);
        if (write !== expected) begin
            $display("ERROR: time %0d ns: write expected %b, actual %b", $time, expected, write);
            abortRun();
        end
    endtask

    // failed assertions of the bound checker
    task automatic pollAssertions();
        if (u_dut.u_sva.failures != 0) begin
            $display("bound assertion failed before time %0d ns", $time);
            abortRun();
        end
    endtask

    task automatic waitState(cpuState want);
        int cycles;
        cycles = 0;
        while (u_dut.state !== want) begin
            if (cycles == 8) begin
                $display("timeout: core never reached state %s", want.name());
                abortRun();
            end
            @(negedge clock);
            cycles++;
        end
    endtask

    task automatic emit(instrWord w);
        imem[slot] = w;
        slot += 2;
    endtask

    // raise rst and restore memories and reference
    task automatic beginReset();
        @(posedge clock);
        rst <= 1'b1;
        for (int i = 0; i < 32; i++) begin
            imem[i]   = encodeI(ADDI, 2'd3, 2'd3, 5'(i));  // filler adds slot address to R3
            memArr[i] = dataWord'(i * 13) ^ 5'h0a;
            refMem[i] = memArr[i];
        end
        refS    = '0;
        refS.pc = bootPc;
        slot    = 0;
    endtask

    // compare one instruction across its five states
    task automatic runInstr();
        archState nxt;
        instrWord iw;
        opcodeE   op;
        @(negedge clock);
        waitState(IF);
        pollAssertions();
        checkPc(refS.pc);
        checkStrobe(1'b0);
        iw  = imem[refS.pc];
        op  = opcodeE'(iw[11:9]);
        nxt = step(refS, refMem, iw);
        for (int n = 1; n < 5; n++) begin
            @(posedge clock);
            if (n == 3 && op == LW)
                dataIn <= memArr[nxt.addr];  // read data valid through MEM
            @(negedge clock);
            pollAssertions();
            if (u_dut.state !== cpuState'(n)) begin
                $display("state sequence broken at time %0d ns", $time);
                abortRun();
            end
            checkStrobe(n == 3 && op == SW);
            if (n == 3 && (op == LW || op == SW))
                checkData("dataAddr", dataAddr, nxt.addr);
            if (n == 3 && op == SW)
                checkData("dataOut", dataOut, nxt.stData);
        end
        if (nxt.store)
            refMem[nxt.addr] = nxt.stData;
        refS = nxt;
    endtask

    task automatic runProgram(int count);
        repeat (2) @(posedge clock);
        rst <= 1'b0;
        for (int k = 0; k < count; k++)
            runInstr();
    endtask

    initial begin
        void'($urandom(32'hb169));
        // all eight functions in two programs of four
        for (int half = 0; half < 2; half++) begin
            beginReset();
            emit(encodeI(LW, 2'd0, 2'd1, 5'd2));  // R1 = 16 with sign bit set
            emit(encodeI(LW, 2'd0, 2'd2, 5'd1));  // R2 = 7
            for (int f = 0; f < 4; f++) begin
                emit(encodeR(funcE'(half * 4 + f), 2'd1, 2'd2, 2'd3));
                emit(encodeI(SW, 2'd0, 2'd3, 5'(20 + half * 4 + f)));
            end
            runProgram(10);
        end
        // immediates, R0 targets, load/store round trip
        beginReset();
        emit(encodeI(ADDI, 2'd0, 2'd1, 5'h1f));
        emit(encodeI(ADDI, 2'd1, 2'd1, 5'd5));   // 31 + 5 wraps to 4
        emit(encodeI(SUBI, 2'd0, 2'd2, 5'd3));   // 0 - 3 wraps to 29
        emit(encodeI(ADDI, 2'd1, 2'd0, 5'd7));   // R0 target is dropped
        emit(encodeR(ADD, 2'd1, 2'd2, 2'd0));
        emit(encodeI(LW, 2'd0, 2'd0, 5'd2));
        emit(encodeI(SW, 2'd1, 2'd0, 5'd3));     // R0 must store 0
        emit(encodeI(SW, 2'd0, 2'd2, 5'd9));
        emit(encodeI(SUBI, 2'd2, 2'd3, 5'h1e));
        emit(encodeI(SW, 2'd2, 2'd3, 5'd4));     // address 29 + 4 wraps
        emit(encodeI(LW, 2'd1, 2'd3, 5'd1));
        emit(encodeI(SW, 2'd1, 2'd3, 5'd12));
        emit(encodeI(LW, 2'd1, 2'd2, 5'd12));
        emit(encodeI(SW, 2'd0, 2'd2, 5'd30));
        runProgram(14);
        // branch path 0 10 12 14 24 4 6 8 10
        beginReset();
        imem[0]  = encodeI(BEQZ, 2'd0, 2'd0, 5'd4);   // taken
        imem[10] = encodeI(ADDI, 2'd0, 2'd1, 5'd1);
        imem[12] = encodeI(BEQZ, 2'd1, 2'd0, 5'd2);   // not taken
        imem[14] = encodeI(BEQZ, 2'd0, 2'd0, 5'h14);  // imm[4] set
        imem[24] = encodeI(BEQZ, 2'd0, 2'd0, 5'd5);   // 26 + 10 wraps to 4
        imem[4]  = encodeI(SW, 2'd0, 2'd1, 5'd8);
        imem[6]  = encodeI(BEQZ, 2'd1, 2'd0, 5'd1);
        runProgram(9);
        // random programs from legal opcodes only
        for (int p = 0; p < 3; p++) begin
            beginReset();
            for (int i = 0; i < 16; i++)
                emit({3'($urandom_range(5, 0)), 9'($urandom)});
            runProgram(200);
        end
        $display("All tests passed!");
        $finish;
    end

endmodule

/* bench/vsaCore_sva.sv */
// ~~~~~~~~~~~~~~~~~~~~
// vsaCoreSva assertion module and its bind
// state ring, store strobe, pc update timing
// ~~~~~~~~~~~~~~~~~~~~
module vsaCoreSva #(
    parameter vsaIsaPkg::pcAddr resetPc = '0
) (
    input logic                clock,
    input logic                rst,
    input vsaCorePkg::cpuState state,
    input vsaIsaPkg::pcAddr    pc,
    input logic                write
);
    timeunit 1ns;
    timeprecision 1ps;
    import vsaCorePkg::*;

    int unsigned failures = 0;  // count of failed assertions

    // one step of the fixed ring outside reset
    property ringStep(cpuState cur, cpuState nxt);
        @(posedge clock) (!rst && state == cur) |=> (state == nxt);
    endproperty

    ifToId: assert property (ringStep(IF, ID)) else begin
        failures++;
        $error("IF not followed by ID");
    end
    idToEx: assert property (ringStep(ID, EX)) else begin
        failures++;
        $error("ID not followed by EX");
    end
    exToMem: assert property (ringStep(EX, MEM)) else begin
        failures++;
        $error("EX not followed by MEM");
    end
    memToWb: assert property (ringStep(MEM, WB)) else begin
        failures++;
        $error("MEM not followed by WB");
    end
    wbToIf: assert property (ringStep(WB, IF)) else begin
        failures++;
        $error("WB not followed by IF");
    end

    strobeInMem: assert property (@(posedge clock) write |-> state == MEM) else begin
        failures++;
        $error("store strobe seen outside MEM");
    end

    // pc moves only on the edge that ends MEM
    pcAtCommit: assert property (@(posedge clock)
        (!rst && !$past(rst) && pc != $past(pc)) |-> ($past(state) == MEM && state == WB))
    else begin
        failures++;
        $error("pc changed outside the MEM to WB transition");
    end

    pcAfterReset: assert property (@(posedge clock) rst |=> pc == resetPc) else begin
        failures++;
        $error("pc not at reset address after reset");
    end

endmodule

bind vsaCore vsaCoreSva #(.resetPc(resetPc)) u_sva (
    .clock (clock),
    .rst   (rst),
    .state (state),
    .pc    (pc),
    .write (write)
);

/* source/vsaCore.sv */
// ~~~~~~~~~~~~~~~~~~~~
// vsa core top level
// sequencer, register file, ALU, branch unit, commit
// ~~~~~~~~~~~~~~~~~~~~
module vsaCore #(
    parameter vsaIsaPkg::pcAddr resetPc = '0
) (
    input  logic                clock,
    input  logic                rst,
    output vsaIsaPkg::pcAddr    pc,        // instruction address
    input  vsaIsaPkg::instrWord instr,     // sampled end of IF
    output vsaIsaPkg::dataWord  dataAddr,  // registered ALU result
    input  vsaIsaPkg::dataWord  dataIn,    // sampled end of MEM on LW
    output vsaIsaPkg::dataWord  dataOut,   // store data
    output logic                write      // high in MEM of SW
);
    import vsaIsaPkg::*;
    import vsaCorePkg::*;

    cpuState     state;
    decodedInstr decoded;
    pcAddr       npc;
    operandPair  operands;
    dataWord     aluOut;
    branchResult branch;
    regWrite     wb;

    vsaSequencer #(.resetPc(resetPc)) u_seq (
        .clock   (clock),
        .rst     (rst),
        .pc      (pc),
        .instr   (instr),
        .state   (state),
        .decoded (decoded),
        .npc     (npc)
    );

    vsaRegFile u_regs (
        .clock    (clock),
        .rst      (rst),
        .state    (state),
        .decoded  (decoded),
        .wb       (wb),
        .operands (operands)
    );

    vsaAlu u_alu (
        .clock    (clock),
        .rst      (rst),
        .state    (state),
        .decoded  (decoded),
        .operands (operands),
        .aluOut   (aluOut)
    );

    // runs beside the ALU in EX
    vsaBranchUnit u_branch (
        .clock    (clock),
        .rst      (rst),
        .state    (state),
        .decoded  (decoded),
        .operands (operands),
        .npc      (npc),
        .branch   (branch)
    );

    vsaCommit #(.resetPc(resetPc)) u_commit (
        .clock   (clock),
        .rst     (rst),
        .state   (state),
        .decoded (decoded),
        .aluOut  (aluOut),
        .branch  (branch),
        .npc     (npc),
        .dataIn  (dataIn),
        .pc      (pc),
        .write   (write),
        .wb      (wb)
    );

    assign dataAddr = aluOut;      // address comes straight from EX
    assign dataOut  = operands.b;

endmodule

/* source/vsaCommit.sv */
// ~~~~~~~~~~~~~~~~~~~~
// commit stage with pc register, load data,
// store strobe and write-back request
// ~~~~~~~~~~~~~~~~~~~~
module vsaCommit #(
    parameter vsaIsaPkg::pcAddr resetPc = '0
) (
    input  logic                    clock,
    input  logic                    rst,
    input  vsaCorePkg::cpuState     state,
    input  vsaIsaPkg::decodedInstr  decoded,
    input  vsaIsaPkg::dataWord      aluOut,
    input  vsaCorePkg::branchResult branch,
    input  vsaIsaPkg::pcAddr        npc,
    input  vsaIsaPkg::dataWord      dataIn,
    output vsaIsaPkg::pcAddr        pc,
    output logic                    write,
    output vsaCorePkg::regWrite     wb
);
    import vsaIsaPkg::*;
    import vsaCorePkg::*;

    dataWord lmd;        // load data register
    logic    takeBranch;
    logic    writesReg;  // instruction has a register result

    assign takeBranch = (decoded.opcode == BEQZ) && branch.taken;

    always_ff @(posedge clock) begin
        if (rst) begin
            pc  <= resetPc;
            lmd <= '0;
        end else if (state == MEM) begin
            pc <= takeBranch ? branch.target : npc;  // only pc update point
            if (decoded.opcode == LW)
                lmd <= dataIn;
        end
    end

    assign write = (state == MEM) && (decoded.opcode == SW);  // store strobe

    always_comb begin
        writesReg = decoded.opcode inside {ALUOP, ADDI, SUBI, LW};
        wb.enable = (state == WB) && writesReg;
        // R-format writes dst, I-format writes src2
        wb.index  = (decoded.opcode == ALUOP) ? decoded.dst : decoded.src2;
        wb.data   = (decoded.opcode == LW) ? lmd : aluOut;
    end

endmodule

/* source/vsaBranchUnit.sv */
// ~~~~~~~~~~~~~~~~~~~~
// branch target adder and
// zero test for BEQZ
// ~~~~~~~~~~~~~~~~~~~~
module vsaBranchUnit (
    input  logic                    clock,
    input  logic                    rst,
    input  vsaCorePkg::cpuState     state,
    input  vsaIsaPkg::decodedInstr  decoded,
    input  vsaCorePkg::operandPair  operands,
    input  vsaIsaPkg::pcAddr        npc,
    output vsaCorePkg::branchResult branch
);
    import vsaIsaPkg::*;
    import vsaCorePkg::*;

    pcAddr offset;  // word offset, imm[4] not used

    assign offset = {decoded.imm[3:0], 1'b0};

    always_ff @(posedge clock) begin
        if (rst) begin
            branch <= '0;
        end else if (state == EX) begin
            if (decoded.opcode == BEQZ) begin
                branch.target <= npc + offset;        // wraps at 32
                branch.taken  <= (operands.a == '0);
            end else begin
                branch.taken <= 1'b0;  // target left stale
            end
        end
    end

endmodule

/* source/vsaAlu.sv */
// ~~~~~~~~~~~~~~~~~~~~
// data ALU for the EX state
// register, immediate and address math
// ~~~~~~~~~~~~~~~~~~~~
module vsaAlu (
    input  logic                   clock,
    input  logic                   rst,
    input  vsaCorePkg::cpuState    state,
    input  vsaIsaPkg::decodedInstr decoded,
    input  vsaCorePkg::operandPair operands,
    output vsaIsaPkg::dataWord     aluOut
);
    import vsaIsaPkg::*;
    import vsaCorePkg::*;

    dataWord a;
    dataWord b;
    dataWord rResult;  // R-format result

    assign a = operands.a;
    assign b = operands.b;

    // everything wraps mod 32 by width
    always_comb begin
        case (decoded.func)
            ADD:     rResult = a + b;
            SUB:     rResult = a - b;
            AND:     rResult = a & b;
            OR:      rResult = a | b;
            XOR:     rResult = a ^ b;
            NOT:     rResult = ~a;               // b ignored
            SRL:     rResult = {1'b0, a[4:1]};   // zero fill
            default: rResult = {a[4], a[4:1]};   // SRA, sign kept
        endcase
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            aluOut <= '0;
        end else if (state == EX) begin
            case (decoded.opcode)
                LW, SW: aluOut <= a + decoded.imm;  // data address
                ADDI:   aluOut <= a + decoded.imm;
                SUBI:   aluOut <= a - decoded.imm;
                ALUOP:  aluOut <= rResult;
                default: ;                          // BEQZ holds last value
            endcase
        end
    end

endmodule

/* source/vsaSequencer.sv */
// ~~~~~~~~~~~~~~~~~~~~
// five-state control FSM
// instruction register, next pc, field decode
// ~~~~~~~~~~~~~~~~~~~~
module vsaSequencer #(
    parameter vsaIsaPkg::pcAddr resetPc = '0
) (
    input  logic                   clock,
    input  logic                   rst,
    input  vsaIsaPkg::pcAddr       pc,
    input  vsaIsaPkg::instrWord    instr,
    output vsaCorePkg::cpuState    state,
    output vsaIsaPkg::decodedInstr decoded,
    output vsaIsaPkg::pcAddr       npc
);
    import vsaIsaPkg::*;
    import vsaCorePkg::*;

    instrWord ir;         // held for the whole instruction
    cpuState  nextState;

    // fixed ring, no stalls
    always_comb begin
        case (state)
            IF:      nextState = ID;
            ID:      nextState = EX;
            EX:      nextState = MEM;
            MEM:     nextState = WB;
            default: nextState = IF;  // WB and any stray code
        endcase
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            state <= IF;
            ir    <= '0;
            npc   <= resetPc + pcStep;
        end else begin
            state <= nextState;
            if (state == IF) begin
                ir  <= instr;         // instruction valid at end of IF
                npc <= pc + pcStep;   // wraps at 32
            end
        end
    end

    // split ir into fields
    // dst/func and imm share low bits
    always_comb begin
        decoded.opcode = opcodeE'(ir[11:9]);
        decoded.src1   = ir[8:7];
        decoded.src2   = ir[6:5];
        decoded.dst    = ir[4:3];
        decoded.func   = funcE'(ir[2:0]);
        decoded.imm    = ir[4:0];
    end

endmodule

/* source/vsaRegFile.sv */
// ~~~~~~~~~~~~~~~~~~~~
// register file, R1..R3 plus zero R0
// operand latch and write-back port
// ~~~~~~~~~~~~~~~~~~~~
module vsaRegFile (
    input  logic                   clock,
    input  logic                   rst,
    input  vsaCorePkg::cpuState    state,
    input  vsaIsaPkg::decodedInstr decoded,
    input  vsaCorePkg::regWrite    wb,
    output vsaCorePkg::operandPair operands
);
    import vsaIsaPkg::*;
    import vsaCorePkg::*;

    dataWord regs [1:numRegs-1];  // no storage behind R0

    // R0 always reads as zero
    function automatic dataWord readReg(input regIndex idx);
        if (idx == '0)
            return '0;
        return regs[idx];
    endfunction

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 1; i < numRegs; i++)
                regs[i] <= '0;
            operands <= '0;
        end else begin
            // operands sampled once per instruction
            if (state == ID) begin
                operands.a <= readReg(decoded.src1);
                operands.b <= readReg(decoded.src2);
            end
            if (wb.enable && wb.index != '0)  // writes to R0 dropped here
                regs[wb.index] <= wb.data;
        end
    end

endmodule

/* source/vsaCorePkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// vsa core microarchitecture package
// control states and inter-block structs
// ~~~~~~~~~~~~~~~~~~~~
package vsaCorePkg;

    // one instruction per pass through all five
    typedef enum logic [2:0] {
        IF  = 3'd0,  // fetch
        ID  = 3'd1,  // decode, operand read
        EX  = 3'd2,  // alu + branch target
        MEM = 3'd3,  // data access, pc update
        WB  = 3'd4   // register write-back
    } cpuState;

    // latched source operands
    typedef struct packed {
        vsaIsaPkg::dataWord a;  // from src1
        vsaIsaPkg::dataWord b;  // from src2, also store data
    } operandPair;

    // branch unit result, registered in EX
    typedef struct packed {
        vsaIsaPkg::pcAddr target;
        logic             taken;
    } branchResult;

    // write-back request toward the register file
    typedef struct packed {
        logic               enable;
        vsaIsaPkg::regIndex index;
        vsaIsaPkg::dataWord data;
    } regWrite;

endpackage

/* source/vsaIsaPkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// vsa instruction set package
// widths, opcode and function enums,
// decoded instruction fields
// ~~~~~~~~~~~~~~~~~~~~
package vsaIsaPkg;

    // fixed by the 12-bit instruction format
    localparam int dataWidth = 5;
    localparam int numRegs   = 4;  // R0 hard-wired, R1..R3 real

    typedef logic [dataWidth-1:0] dataWord;   // register / memory value
    typedef logic [4:0]           pcAddr;     // instruction address
    typedef logic [1:0]           regIndex;   // register field
    typedef logic [11:0]          instrWord;  // raw instruction
    typedef logic [4:0]           immField;   // I-format immediate

    localparam pcAddr pcStep = 5'd2;  // instructions are two bytes apart

    // major opcode in bits 11:9, codes 6 and 7 unused
    typedef enum logic [2:0] {
        LW    = 3'd0,
        SW    = 3'd1,
        BEQZ  = 3'd2,
        ALUOP = 3'd3,  // R-format, see func
        ADDI  = 3'd4,
        SUBI  = 3'd5
    } opcodeE;

    // R-format function in bits 2:0
    typedef enum logic [2:0] {
        ADD, SUB, AND, OR, XOR, NOT, SRL, SRA
    } funcE;

    // dst/func and imm overlap in the raw word
    typedef struct packed {
        opcodeE  opcode;
        regIndex src1;  // bits 8:7
        regIndex src2;  // bits 6:5, also I-format destination
        regIndex dst;   // bits 4:3
        funcE    func;  // bits 2:0
        immField imm;   // bits 4:0
    } decodedInstr;

endpackage
